/* list.f */
+incdir+design
+incdir+dv
design/dot11_tx_pkg.sv
design/stream_fifo.sv
design/fcs_crc32.sv
design/psdu_fetch.sv
design/data_field_seq.sv
design/conv_encoder.sv
design/dot11_tx_top.sv
dv/tb_dot11_tx.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_dot11_tx \
    -Mdir obj_dir -o tb_dot11_tx
./obj_dir/tb_dot11_tx | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    exit 1
fi
exit 0

/* dv/tx_ref_model.svh */
// Reference model of the DATA field path, included into the testbench module

// Payload bytes of the packet under test, FCS not included
byte unsigned payload[$];
// Expected {a, b} pairs in transfer order
logic [1:0]   exp_pairs[$];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Legacy rate table, anything unknown runs at 6 Mbps
function automatic int ndbps_for(input logic [3:0] rate);
    case (rate)
        4'b1011: return 24;
        4'b1111: return 36;
        4'b1010: return 48;
        4'b1110: return 72;
        4'b1001: return 96;
        4'b1101: return 144;
        4'b1000: return 192;
        4'b1100: return 216;
        default: return 24;
    endcase
endfunction

// SERVICE, PSDU with FCS and tail, rounded up to whole symbols
function automatic int pair_count(input int ndbps, input int len);
    return ((16 + 8 * len + 6 + ndbps - 1) / ndbps) * ndbps;
endfunction

// Byte-wise 802.3 CRC-32, reflected
function automatic logic [31:0] crc32_of_payload();
    logic [31:0] c;
    int          k;
    c = 32'hffff_ffff;
    foreach (payload[i]) begin
        c = c ^ {24'h0, payload[i]};
        for (k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
        end
    end
    return ~c;
endfunction

function automatic void build_expected(input int ndbps, input logic [6:0] seed);
    logic        field[$];
    logic [31:0] fcs;
    logic [6:0]  scr;
    logic [6:0]  win;
    logic        fbit;
    logic        b;
    int          tail_at;
    int          total;
    int          i;
    int          k;
    field.delete();
    exp_pairs.delete();
    fcs = crc32_of_payload();
    for (i = 0; i < 16; i++) begin
        field.push_back(1'b0);
    end
    foreach (payload[n]) begin
        for (k = 0; k < 8; k++) begin
            field.push_back(payload[n][k]);
        end
    end
    // FCS low byte first, LSB first
    for (k = 0; k < 32; k++) begin
        field.push_back(fcs[k]);
    end
    tail_at = field.size();
    total   = pair_count(ndbps, payload.size() + 4);
    scr     = seed;
    win     = '0;
    for (i = 0; i < total; i++) begin
        if (i >= tail_at && i < tail_at + 6) begin
            b = 1'b0;
        end else begin
            // State x7..x1 in scr[6:0], x7 ^ x4 feeds back
            fbit = scr[6] ^ scr[3];
            b    = ((i < tail_at) ? field[i] : 1'b0) ^ fbit;
            scr  = {scr[5:0], fbit};
        end
        // win[6] is the current bit, win[0] the one six bits back
        win = {b, win[6:1]};
        exp_pairs.push_back({^(win & 7'o133), ^(win & 7'o171)});
    end
endfunction

/* dv/tb_dot11_tx.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dot11_tx_defines.svh"

module tb_dot11_tx
    import dot11_tx_pkg::*;
();

    localparam int          N_PKT        = 23;
    localparam int          QUIET_CYCLES = 30;
    localparam logic [31:0] SEED         = 32'h4da1d108;

    logic                  clk;
    logic                  reset_int;
    logic                  tx_start;
    logic [6:0]            scram_seed;
    logic [`TX_ADDR_W-1:0] bram_addr;
    logic [`TX_WORD_W-1:0] bram_din;
    enc_pair_t             enc_pair;
    logic                  enc_valid;
    logic                  enc_ready;
    logic                  busy;
    logic                  tx_done;

    logic [`TX_WORD_W-1:0] mem [1 << `TX_ADDR_W];
    logic [3:0]            pkt_rate [N_PKT];
    int                    pkt_len  [N_PKT];
    logic [6:0]            pkt_seed [N_PKT];
    logic [31:0]           pkt_data [N_PKT];
    logic [31:0]           rng;
    logic [31:0]           rdy_rng;
    logic                  stall_en;
    int                    errors       = 0;
    int                    mon_errors   = 0;
    int                    done_count   = 0;
    int                    pkt_id       = -1;
    int                    exp_total    = 0;
    int                    cycle_limit  = 0;
    int                    tests_passed = 0;
    int                    tests_failed = 0;

    `include "tx_ref_model.svh"

    dot11_tx_top dut_i (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_tx_start   (tx_start),
        .i_scram_seed (scram_seed),
        .o_bram_addr  (bram_addr),
        .i_bram_din   (bram_din),
        .o_enc_pair   (enc_pair),
        .o_enc_valid  (enc_valid),
        .i_enc_ready  (enc_ready),
        .o_busy       (busy),
        .o_tx_done    (tx_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory with one cycle of read latency
    initial begin
        bram_din = '0;
        forever begin
            @(posedge clk);
            bram_din <= mem[bram_addr];
        end
    end

    // Output back-pressure, low about half the time when enabled
    initial begin
        enc_ready = 1'b1;
        rdy_rng   = ~SEED;
        forever begin
            @(posedge clk);
            rdy_rng = xorshift32(rdy_rng);
            enc_ready <= stall_en ? rdy_rng[16] : 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Pair and done monitor
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!reset_int && enc_valid && enc_ready) begin
            if (exp_pairs.size() == 0) begin
                $display("Extra pair %h arrived after the expected stream of packet %0d",
                         {enc_pair.a, enc_pair.b}, pkt_id);
                mon_errors++;
            end else begin
                if ({enc_pair.a, enc_pair.b} != exp_pairs[0]) begin
                    $display("Fail o_enc_pair packet %0d pair %0d expected %h actual %h",
                             pkt_id, exp_total - exp_pairs.size(), exp_pairs[0],
                             {enc_pair.a, enc_pair.b});
                    mon_errors++;
                end
                void'(exp_pairs.pop_front());
            end
        end
        if (!reset_int && tx_done) begin
            done_count++;
            if (exp_pairs.size() != 0) begin
                $display("Done pulse came with %0d pairs of packet %0d still missing",
                         exp_pairs.size(), pkt_id);
                mon_errors++;
            end
            if (busy) begin
                $display("Fail o_busy on the done cycle expected 0 actual %h", busy);
                mon_errors++;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    task automatic plan_packets();
        int p;
        pkt_rate[0] = 4'b1011;
        pkt_len[0]  = 24;
        for (p = 1; p < N_PKT; p++) begin
            rng = xorshift32(rng);
            // The eight table codes are exactly those with bit 3 set
            pkt_rate[p] = (p == 21) ? {1'b0, rng[2:0]} : {1'b1, rng[2:0]};
            rng = xorshift32(rng);
            pkt_len[p] = 5 + int'(rng % 32'd196);
        end
        for (p = 0; p < N_PKT; p++) begin
            rng = xorshift32(rng);
            pkt_seed[p] = 7'(1 + rng % 32'd127);
            rng = xorshift32(rng);
            pkt_data[p] = rng | 32'h1;
        end
    endtask

    function automatic int run_budget(input int p);
        return pair_count(ndbps_for(pkt_rate[p]), pkt_len[p]) + (pkt_len[p] + 3) / 8 + 1 + 50;
    endfunction

    task automatic load_packet(input int p);
        logic [31:0] d;
        logic [31:0] lo;
        int          n_pay;
        int          w;
        int          j;
        n_pay = pkt_len[p] - 4;
        payload.delete();
        d  = xorshift32(pkt_data[p]);
        lo = d;
        d  = xorshift32(d);
        // Random filler around the rate and length fields
        mem[0] = {d, lo[14:0], 12'(pkt_len[p]), lo[15], pkt_rate[p]};
        for (w = 1; w <= (n_pay + 7) / 8; w++) begin
            d  = xorshift32(d);
            lo = d;
            d  = xorshift32(d);
            mem[w] = {d, lo};
            for (j = 0; j < 8; j++) begin
                if (payload.size() < n_pay) begin
                    payload.push_back(mem[w][8*j +: 8]);
                end
            end
        end
    endtask

    task automatic run_packet(input int p, input logic stall, input logic stray);
        int done_before;
        load_packet(p);
        build_expected(ndbps_for(pkt_rate[p]), pkt_seed[p]);
        exp_total = exp_pairs.size();
        pkt_id    = p;
        @(posedge clk);
        stall_en   <= stall;
        scram_seed <= pkt_seed[p];
        tx_start   <= 1'b1;
        done_before = done_count;
        @(posedge clk);
        tx_start <= 1'b0;
        if (stray) begin
            repeat (4) @(posedge clk);
            if (!busy) begin
                $display("The second start of packet %0d was driven while the DUT was idle", p);
                errors++;
            end
            tx_start <= 1'b1;
            @(posedge clk);
            tx_start <= 1'b0;
        end
        while (done_count == done_before) begin
            @(posedge clk);
        end
        stall_en <= 1'b0;
        // Nothing may follow the done pulse
        repeat (QUIET_CYCLES) @(posedge clk);
        if (done_count != done_before + 1) begin
            $display("Done pulsed %0d times for packet %0d", done_count - done_before, p);
            errors++;
        end
        if (busy) begin
            $display("Fail o_busy after packet %0d expected 0 actual %h", p, busy);
            errors++;
        end
        // The next start must find the header address on the port
        if (bram_addr !== '0) begin
            $display("Fail o_bram_addr after packet %0d expected %h actual %h",
                     p, `TX_ADDR_W'(0), bram_addr);
            errors++;
        end
    endtask

    task automatic check_low(input string name, input logic value);
        if (value !== 1'b0) begin
            $display("Fail %s expected 0 actual %h", name, value);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int mark);
        if (errors + mon_errors == mark) begin
            tests_passed++;
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errors + mon_errors - mark);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int p;
        int mark;
        reset_int  = 1'b1;
        tx_start   = 1'b0;
        scram_seed = 7'h7f;
        stall_en   = 1'b0;
        rng        = SEED;
        for (p = 0; p < (1 << `TX_ADDR_W); p++) begin
            mem[p] = {4{6'h2b, `TX_ADDR_W'(p)}};
        end
        plan_packets();
        for (p = 0; p < N_PKT; p++) begin
            cycle_limit += 4 * run_budget(p);
        end
        // Packets 1 to 20 run a second time with back-pressure
        for (p = 1; p <= 20; p++) begin
            cycle_limit += 4 * run_budget(p);
        end

        mark = errors + mon_errors;
        repeat (5) @(posedge clk);
        reset_int <= 1'b0;
        repeat (20) begin
            @(posedge clk);
            check_low("o_enc_valid", enc_valid);
            check_low("o_busy", busy);
            check_low("o_tx_done", tx_done);
        end
        finish_test("reset_idle", mark);

        mark = errors + mon_errors;
        run_packet(0, 1'b0, 1'b0);
        finish_test("basic_6mbps", mark);

        mark = errors + mon_errors;
        for (p = 1; p <= 20; p++) begin
            run_packet(p, 1'b0, 1'b0);
        end
        finish_test("random_packets", mark);

        mark = errors + mon_errors;
        for (p = 1; p <= 20; p++) begin
            run_packet(p, 1'b1, 1'b0);
        end
        finish_test("random_backpressure", mark);

        mark = errors + mon_errors;
        run_packet(21, 1'b0, 1'b0);
        finish_test("unknown_rate", mark);

        mark = errors + mon_errors;
        run_packet(22, 1'b0, 1'b1);
        finish_test("done_and_busy_start", mark);

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && errors + mon_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog on the total run length
    initial begin
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run took more than %0d cycles", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* design/dot11_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dot11_tx_defines.svh"

module dot11_tx_top
    import dot11_tx_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_int,
    input  logic                  i_tx_start,
    input  logic [6:0]            i_scram_seed,
    output logic [`TX_ADDR_W-1:0] o_bram_addr,
    input  logic [`TX_WORD_W-1:0] i_bram_din,
    output enc_pair_t             o_enc_pair,
    output logic                  o_enc_valid,
    input  logic                  i_enc_ready,
    output logic                  o_busy,
    output logic                  o_tx_done
);

    tx_hdr_t               hdr;
    logic                  hdr_valid;
    logic [`TX_WORD_W-1:0] fetch_word;
    logic                  fetch_word_valid;
    logic                  fetch_word_ready;
    logic [`TX_WORD_W-1:0] seq_word;
    logic                  seq_word_valid;
    logic                  seq_word_ready;
    logic                  bit_data;
    logic                  bit_valid;
    logic                  bit_first;
    logic                  bit_ready;
    enc_pair_t             enc_pair;
    logic                  enc_pair_valid;
    logic                  enc_pair_ready;
    logic                  enc_idle;
    logic                  pair_fifo_empty;
    logic                  pairs_drained;

    // Nothing left once the FIFO is empty and the encoder holds no pair
    assign pairs_drained = pair_fifo_empty && enc_idle;

    //////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////

    psdu_fetch fetch_i (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_tx_start   (i_tx_start),
        .i_busy       (o_busy),
        .o_bram_addr  (o_bram_addr),
        .i_bram_din   (i_bram_din),
        .o_hdr        (hdr),
        .o_hdr_valid  (hdr_valid),
        .o_word       (fetch_word),
        .o_word_valid (fetch_word_valid),
        .i_word_ready (fetch_word_ready)
    );

    stream_fifo #(
        .T     (logic [`TX_WORD_W-1:0]),
        .DEPTH (`TX_WORD_FIFO_DEPTH)
    ) word_fifo_i (
        .clk       (clk),
        .reset_int (reset_int),
        .i_data    (fetch_word),
        .i_valid   (fetch_word_valid),
        .o_ready   (fetch_word_ready),
        .o_data    (seq_word),
        .o_valid   (seq_word_valid),
        .i_ready   (seq_word_ready),
        .o_empty   ()
    );

    //////////////////////////////////////////////////
    // DATA field bits
    //////////////////////////////////////////////////

    data_field_seq seq_i (
        .clk             (clk),
        .reset_int       (reset_int),
        .i_scram_seed    (i_scram_seed),
        .i_hdr           (hdr),
        .i_hdr_valid     (hdr_valid),
        .i_word          (seq_word),
        .i_word_valid    (seq_word_valid),
        .o_word_ready    (seq_word_ready),
        .o_bit_data      (bit_data),
        .o_bit_valid     (bit_valid),
        .o_bit_first     (bit_first),
        .o_bit_last      (),
        .i_bit_ready     (bit_ready),
        .o_busy          (o_busy),
        .i_pairs_drained (pairs_drained),
        .o_tx_done       (o_tx_done)
    );

    //////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////

    conv_encoder enc_i (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_bit        (bit_data),
        .i_bit_valid  (bit_valid),
        .i_bit_first  (bit_first),
        .o_bit_ready  (bit_ready),
        .o_pair       (enc_pair),
        .o_pair_valid (enc_pair_valid),
        .i_pair_ready (enc_pair_ready),
        .o_idle       (enc_idle)
    );

    stream_fifo #(
        .T     (enc_pair_t),
        .DEPTH (`TX_ENC_FIFO_DEPTH)
    ) pair_fifo_i (
        .clk       (clk),
        .reset_int (reset_int),
        .i_data    (enc_pair),
        .i_valid   (enc_pair_valid),
        .o_ready   (enc_pair_ready),
        .o_data    (o_enc_pair),
        .o_valid   (o_enc_valid),
        .i_ready   (i_enc_ready),
        .o_empty   (pair_fifo_empty)
    );

endmodule

`default_nettype wire

/* design/conv_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_encoder
    import dot11_tx_pkg::*;
(
    input  logic      clk,
    input  logic      reset_int,
    input  logic      i_bit,
    input  logic      i_bit_valid,
    input  logic      i_bit_first,
    output logic      o_bit_ready,
    output enc_pair_t o_pair,
    output logic      o_pair_valid,
    input  logic      i_pair_ready,
    output logic      o_idle
);

    logic [5:0] hist;
    logic [5:0] hist_in;
    logic       accept;
    enc_pair_t  pair_d;

    // hist[0] is the previous bit, hist[5] the oldest
    assign hist_in = i_bit_first ? 6'd0 : hist;

    // Generator 133 taps delays 0,2,3,5,6 and 171 taps 0,1,2,3,6
    assign pair_d.a = i_bit ^ hist_in[1] ^ hist_in[2] ^ hist_in[4] ^ hist_in[5];
    assign pair_d.b = i_bit ^ hist_in[0] ^ hist_in[1] ^ hist_in[2] ^ hist_in[5];

    // Take a bit when the output register is empty or draining
    assign o_bit_ready = !o_pair_valid || i_pair_ready;
    assign accept      = i_bit_valid && o_bit_ready;
    assign o_idle      = !o_pair_valid;

    always_ff @(posedge clk) begin
        if (reset_int) begin
            hist         <= '0;
            o_pair_valid <= 1'b0;
        end else if (accept) begin
            hist         <= {hist_in[4:0], i_bit};
            o_pair_valid <= 1'b1;
        end else if (i_pair_ready) begin
            o_pair_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_pair <= pair_d;
        end
    end

endmodule

`default_nettype wire

/* design/data_field_seq.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dot11_tx_defines.svh"

module data_field_seq
    import dot11_tx_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_int,
    input  logic [6:0]            i_scram_seed,
    input  tx_hdr_t               i_hdr,
    input  logic                  i_hdr_valid,
    input  logic [`TX_WORD_W-1:0] i_word,
    input  logic                  i_word_valid,
    output logic                  o_word_ready,
    output logic                  o_bit_data,
    output logic                  o_bit_valid,
    output logic                  o_bit_first,
    output logic                  o_bit_last,
    input  logic                  i_bit_ready,
    output logic                  o_busy,
    input  logic                  i_pairs_drained,
    output logic                  o_tx_done
);

    localparam int WB = $clog2(`TX_WORD_W);
    localparam int FB = $clog2(`TX_FCS_BITS);

    seq_state_e               state;
    seq_state_e               next_state;
    tx_hdr_t                  hdr_q;
    logic [`TX_LEN_W+2:0]     bit_cnt;
    logic [`TX_LEN_W+2:0]     psdu_bits;
    logic [8:0]               sym_pos;
    logic [6:0]               lfsr;
    logic                     fb;
    logic                     raw_bit;
    logic                     field_end;
    logic                     sym_end;
    logic                     accept;
    logic                     crc_en;
    logic [`TX_FCS_BITS-1:0]  crc_fcs;

    // Payload bits exclude the FCS bytes
    assign psdu_bits = {hdr_q.psdu_len - `TX_LEN_W'(4), 3'b000};
    assign sym_end   = sym_pos == hdr_q.n_dbps - 9'd1;
    assign fb        = lfsr[6] ^ lfsr[3];

    //////////////////////////////////////////////////
    // Bit source per field
    //////////////////////////////////////////////////

    always_comb begin
        raw_bit    = 1'b0;
        field_end  = 1'b0;
        next_state = state;
        case (state)
            SERVICE: begin
                field_end  = bit_cnt == `TX_SERVICE_BITS - 1;
                next_state = PSDU;
            end
            PSDU: begin
                raw_bit    = i_word[bit_cnt[WB-1:0]];
                field_end  = bit_cnt == psdu_bits - 1'b1;
                next_state = FCS;
            end
            FCS: begin
                raw_bit    = crc_fcs[bit_cnt[FB-1:0]];
                field_end  = bit_cnt == `TX_FCS_BITS - 1;
                next_state = TAIL;
            end
            TAIL: begin
                field_end  = bit_cnt == `TX_TAIL_BITS - 1;
                next_state = sym_end ? DONE : PAD;
            end
            PAD: begin
                field_end  = sym_end;
                next_state = DONE;
            end
            default: ;
        endcase
    end

    assign o_bit_valid  = (state inside {SERVICE, PSDU, FCS, TAIL, PAD})
                          && (state != PSDU || i_word_valid);
    assign accept       = o_bit_valid && i_bit_ready;
    // Tail bits go out unscrambled
    assign o_bit_data   = (state == TAIL) ? 1'b0 : raw_bit ^ fb;
    assign o_bit_first  = state == SERVICE && bit_cnt == '0;
    assign o_bit_last   = (state == TAIL || state == PAD) && field_end && sym_end;

    // Pop the word after its top bit or the last payload bit
    assign o_word_ready = state == PSDU && i_bit_ready
                          && (field_end || &bit_cnt[WB-1:0]);

    assign o_tx_done = state == DONE && i_pairs_drained;
    assign o_busy    = (state != IDLE && !o_tx_done) || i_hdr_valid;

    //////////////////////////////////////////////////
    // FCS over the unscrambled payload
    //////////////////////////////////////////////////

    assign crc_en = accept && state == PSDU;

    fcs_crc32 crc_i (
        .clk       (clk),
        .reset_int (reset_int),
        .i_clear   (i_hdr_valid),
        .i_en      (crc_en),
        .i_bit     (raw_bit),
        .o_fcs     (crc_fcs)
    );

    //////////////////////////////////////////////////
    // Sequencer FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_int) begin
            state   <= IDLE;
            hdr_q   <= '0;
            bit_cnt <= '0;
            sym_pos <= '0;
            lfsr    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_hdr_valid) begin
                        hdr_q   <= i_hdr;
                        lfsr    <= i_scram_seed;
                        bit_cnt <= '0;
                        sym_pos <= '0;
                        state   <= SERVICE;
                    end
                end
                DONE: begin
                    // Wait for the last pair to leave the output FIFO
                    if (i_pairs_drained) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    if (accept) begin
                        bit_cnt <= field_end ? '0 : bit_cnt + 1'b1;
                        sym_pos <= sym_end ? '0 : sym_pos + 1'b1;
                        // LFSR holds over the tail
                        if (state != TAIL) begin
                            lfsr <= {lfsr[5:0], fb};
                        end
                        if (field_end) begin
                            state <= next_state;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/psdu_fetch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dot11_tx_defines.svh"

module psdu_fetch
    import dot11_tx_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_int,
    input  logic                  i_tx_start,
    input  logic                  i_busy,
    output logic [`TX_ADDR_W-1:0] o_bram_addr,
    input  logic [`TX_WORD_W-1:0] i_bram_din,
    output tx_hdr_t               o_hdr,
    output logic                  o_hdr_valid,
    output logic [`TX_WORD_W-1:0] o_word,
    output logic                  o_word_valid,
    input  logic                  i_word_ready
);

    logic [`TX_ADDR_W-1:0] addr_q;
    logic [`TX_ADDR_W-1:0] last_addr;
    logic [`TX_LEN_W-1:0]  hdr_len;
    logic [`TX_LEN_W:0]    n_words;
    logic                  hdr_rd;
    logic                  active;
    logic                  rd_pend;
    logic                  skid_vld;
    logic [`TX_WORD_W-1:0] skid_q;
    logic                  issue;

    //////////////////////////////////////////////////
    // Header decode
    //////////////////////////////////////////////////

    // Word 0 arrives the cycle after the start
    assign hdr_len     = i_bram_din[5 +: `TX_LEN_W];
    assign o_hdr_valid = hdr_rd;
    assign o_hdr       = '{n_dbps: rate_to_ndbps(i_bram_din[3:0]), psdu_len: hdr_len};

    // Payload words = ceil((len - 4) / 8)
    assign n_words = ({1'b0, hdr_len} + (`TX_LEN_W+1)'(3)) >> 3;

    //////////////////////////////////////////////////
    // Payload read and skid
    //////////////////////////////////////////////////

    // Only read when the returning word is sure to find a place
    assign issue = active && !skid_vld && !(rd_pend && !i_word_ready);

    assign o_bram_addr  = addr_q;
    assign o_word_valid = skid_vld || rd_pend;
    assign o_word       = skid_vld ? skid_q : i_bram_din;

    always_ff @(posedge clk) begin
        if (reset_int) begin
            addr_q    <= '0;
            last_addr <= '0;
            hdr_rd    <= 1'b0;
            active    <= 1'b0;
            rd_pend   <= 1'b0;
            skid_vld  <= 1'b0;
        end else begin
            hdr_rd   <= i_tx_start && !i_busy;
            rd_pend  <= issue;
            skid_vld <= o_word_valid && !i_word_ready;
            if (hdr_rd) begin
                last_addr <= n_words[`TX_ADDR_W-1:0];
                addr_q    <= `TX_ADDR_W'(1);
                active    <= 1'b1;
            end else if (issue) begin
                // Park at address 0 so the next start reads the header
                if (addr_q == last_addr) begin
                    addr_q <= '0;
                    active <= 1'b0;
                end else begin
                    addr_q <= addr_q + 1'b1;
                end
            end
        end
    end

    // Catch the word in flight while the output is stalled
    always_ff @(posedge clk) begin
        if (!skid_vld) begin
            skid_q <= i_bram_din;
        end
    end

endmodule

`default_nettype wire

/* design/fcs_crc32.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dot11_tx_defines.svh"

module fcs_crc32
    import dot11_tx_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_int,
    input  logic                    i_clear,
    input  logic                    i_en,
    input  logic                    i_bit,
    output logic [`TX_FCS_BITS-1:0] o_fcs
);

    // 802.3 polynomial in reflected form
    localparam logic [`TX_FCS_BITS-1:0] POLY_REFL = 32'hEDB8_8320;

    logic [`TX_FCS_BITS-1:0] crc_q;
    logic                    fb;

    assign fb    = crc_q[0] ^ i_bit;
    assign o_fcs = ~crc_q;

    always_ff @(posedge clk) begin
        if (reset_int || i_clear) begin
            crc_q <= '1;
        end else if (i_en) begin
            crc_q <= (crc_q >> 1) ^ (fb ? POLY_REFL : '0);
        end
    end

endmodule

`default_nettype wire

/* design/stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo
    import dot11_tx_pkg::*;
#(
    parameter type T     = enc_pair_t,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic reset_int,
    input  T     i_data,
    input  logic i_valid,
    output logic o_ready,
    output T     o_data,
    output logic o_valid,
    input  logic i_ready,
    output logic o_empty
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    T                mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            wr_en;
    logic            rd_en;

    assign o_empty = count == '0;
    assign o_ready = count != CW'(DEPTH);
    assign o_valid = !o_empty;
    assign o_data  = mem[rd_ptr];

    assign wr_en = i_valid && o_ready;
    assign rd_en = o_valid && i_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_int) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/dot11_tx_pkg.sv */
`default_nettype none
`include "dot11_tx_defines.svh"

package dot11_tx_pkg;

    // Decoded header word
    typedef struct packed {
        logic [8:0]           n_dbps;
        logic [`TX_LEN_W-1:0] psdu_len;
    } tx_hdr_t;

    // Encoder output, a from generator 133 and b from 171
    typedef struct packed {
        logic a;
        logic b;
    } enc_pair_t;

    typedef enum logic [2:0] {
        IDLE,
        SERVICE,
        PSDU,
        FCS,
        TAIL,
        PAD,
        DONE
    } seq_state_e;

    // Legacy rate code to data bits per OFDM symbol
    function automatic logic [8:0] rate_to_ndbps(input logic [3:0] rate);
        case (rate)
            4'b1011: return 9'd24;
            4'b1111: return 9'd36;
            4'b1010: return 9'd48;
            4'b1110: return 9'd72;
            4'b1001: return 9'd96;
            4'b1101: return 9'd144;
            4'b1000: return 9'd192;
            4'b1100: return 9'd216;
            // Unknown codes fall back to 6 Mbps
            default: return 9'd24;
        endcase
    endfunction

endpackage

`default_nettype wire

/* design/dot11_tx_defines.svh */
`ifndef DOT11_TX_DEFINES_SVH
`define DOT11_TX_DEFINES_SVH

// Memory port
`define TX_WORD_W 64
`define TX_ADDR_W 10

// PSDU length in bytes, FCS included
`define TX_LEN_W 12

// DATA field parts around the payload
`define TX_SERVICE_BITS 16
`define TX_FCS_BITS 32
`define TX_TAIL_BITS 6

// Buffering between fetch, sequencer and output
`define TX_WORD_FIFO_DEPTH 4
`define TX_ENC_FIFO_DEPTH 16

`endif
